// File: common/mmu_defines.svh
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// number of fully associative tlb entries
`define MMU_TLB_ENTRIES 8

// sv32 pte flag bits
`define MMU_PTE_V 0
`define MMU_PTE_R 1
`define MMU_PTE_W 2
`define MMU_PTE_X 3
`define MMU_PTE_U 4
`define MMU_PTE_A 6
`define MMU_PTE_D 7

`endif

// File: common/mmu_pkg.sv
package mmu_pkg;

    // csr view seen by the mmu
    typedef struct packed {
        logic        enable;     // satp.mode sv32
        logic [21:0] satp_ppn;   // root table
        logic [8:0]  asid;
        logic        mxr;
        logic        sum;
    } mmu_csr_t;

    typedef struct packed {
        logic [31:0] vaddr;
        logic        is_store;
        logic        is_inst;
    } mmu_req_t;

    // one cached translation
    typedef struct packed {
        logic        valid;
        logic [8:0]  asid;
        logic [19:0] vpn;
        logic        superpage;  // 4 MiB leaf at level 1
        logic [31:0] pte;
    } tlb_entry_t;

    // walker refill payload
    typedef struct packed {
        logic [8:0]  asid;
        logic [19:0] vpn;
        logic        superpage;
        logic [31:0] pte;
    } tlb_fill_t;

endpackage

// File: tlb/tlb_entry.sv
module tlb_entry (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                flush_i,
    input  logic                wr_i,
    input  mmu_pkg::tlb_fill_t  fill_i,
    input  logic [19:0]         vpn_i,
    input  logic [8:0]          asid_i,
    output mmu_pkg::tlb_entry_t entry_o,
    output logic                match_o
);
    import mmu_pkg::*;

    logic      valid_q;
    tlb_fill_t data_q;
    logic      vpn_hit;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (wr_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            data_q <= fill_i;
        end
    end

    // superpages compare vpn[1] only
    assign vpn_hit = data_q.superpage ? (data_q.vpn[19:10] == vpn_i[19:10]) :
                                        (data_q.vpn == vpn_i);

    assign match_o = valid_q && (data_q.asid == asid_i) && vpn_hit;

    assign entry_o = '{valid:     valid_q,
                       asid:      data_q.asid,
                       vpn:       data_q.vpn,
                       superpage: data_q.superpage,
                       pte:       data_q.pte};

endmodule

// File: tlb/tlb_refill.sv
`include "mmu_defines.svh"

module tlb_refill (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        fill_valid_i,
    output logic [`MMU_TLB_ENTRIES-1:0] wr_o
);
    localparam int PTR_W = $clog2(`MMU_TLB_ENTRIES);

    logic [PTR_W-1:0] victim_q;

    // round robin so the oldest fill goes first
    always_ff @(posedge clk) begin
        if (rst_i) begin
            victim_q <= '0;
        end else if (fill_valid_i) begin
            if (victim_q == PTR_W'(`MMU_TLB_ENTRIES - 1)) begin
                victim_q <= '0;
            end else begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

    always_comb begin
        wr_o = '0;
        if (fill_valid_i) begin
            wr_o[victim_q] = 1'b1;  // one-hot strobe
        end
    end

endmodule

// File: tlb/tlb_lookup.sv
`include "mmu_defines.svh"

module tlb_lookup (
    input  mmu_pkg::tlb_entry_t         entries_i [`MMU_TLB_ENTRIES],
    input  logic [`MMU_TLB_ENTRIES-1:0] match_i,
    input  mmu_pkg::mmu_req_t           req_i,
    input  mmu_pkg::mmu_csr_t           csr_i,
    output logic                        hit_o,
    output logic [31:0]                 paddr_o,
    output logic                        fault_o
);
    import mmu_pkg::*;

    tlb_entry_t sel;
    logic       perm_ok;
    logic       user_ok;
    logic       ad_ok;

    // walk down so the lowest match wins
    always_comb begin
        sel = '0;
        for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match_i[i]) begin
                sel = entries_i[i];
            end
        end
    end

    assign hit_o = |match_i;

    // 34-bit physical address cut to 32
    assign paddr_o = sel.superpage ? {sel.pte[29:20], req_i.vaddr[21:0]} :
                                     {sel.pte[29:10], req_i.vaddr[11:0]};

    assign perm_ok = req_i.is_inst  ? sel.pte[`MMU_PTE_X] :
                     req_i.is_store ? sel.pte[`MMU_PTE_W] :
                     (sel.pte[`MMU_PTE_R] || (csr_i.mxr && sel.pte[`MMU_PTE_X]));
    assign user_ok = !sel.pte[`MMU_PTE_U] || (csr_i.sum && !req_i.is_inst);
    assign ad_ok   = sel.pte[`MMU_PTE_A] && (!req_i.is_store || sel.pte[`MMU_PTE_D]);

    assign fault_o = hit_o && !(perm_ok && user_ok && ad_ok);

endmodule

// File: ptw/ptw.sv
`include "mmu_defines.svh"

module ptw (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               miss_i,
    input  mmu_pkg::mmu_req_t  req_i,
    input  mmu_pkg::mmu_csr_t  csr_i,
    output logic               mem_req_o,
    output logic [31:0]        mem_addr_o,
    input  logic [31:0]        mem_rdata_i,
    input  logic               mem_rvalid_i,
    output logic               fill_valid_o,
    output mmu_pkg::tlb_fill_t fill_o,
    output logic               fault_o
);
    import mmu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_WAIT,
        S_FILL,
        S_FAULT
    } state_e;

    state_e      state_q;
    logic        mem_req_q;
    logic [31:0] mem_addr_q;
    logic        drop_q;
    logic        level_q;
    logic [19:0] base_q;
    tlb_fill_t   fill_q;
    logic        rvalid;
    logic [9:0]  vpn_idx;
    logic        pte_valid;
    logic        pte_leaf;
    logic        pte_ok;

    assign rvalid  = mem_rvalid_i && !drop_q;
    assign vpn_idx = level_q ? req_i.vaddr[31:22] : req_i.vaddr[21:12];

    assign pte_valid = mem_rdata_i[`MMU_PTE_V] &&
                       !(mem_rdata_i[`MMU_PTE_W] && !mem_rdata_i[`MMU_PTE_R]);
    assign pte_leaf  = mem_rdata_i[`MMU_PTE_R] || mem_rdata_i[`MMU_PTE_X];
    // pointers only at level 1 and superpages need ppn[0] zero
    assign pte_ok    = pte_valid && (pte_leaf ? !(level_q && (mem_rdata_i[19:10] != '0)) :
                                                level_q);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            state_q   <= S_IDLE;
            mem_req_q <= 1'b0;
        end else begin
            mem_req_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (miss_i) begin
                        state_q <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    mem_req_q <= 1'b1;  // single cycle pulse
                    state_q   <= S_WAIT;
                end
                S_WAIT: begin
                    if (rvalid) begin
                        if (!pte_ok) begin
                            state_q <= S_FAULT;
                        end else if (pte_leaf) begin
                            state_q <= S_FILL;
                        end else begin
                            state_q <= S_FETCH;
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;  // fill and fault last one cycle
                end
            endcase
        end
    end

    // swallow the data of a read still in flight at flush
    always_ff @(posedge clk) begin
        if (rst_i) begin
            drop_q <= 1'b0;
        end else if (flush_i && (state_q == S_WAIT) && !mem_rvalid_i) begin
            drop_q <= 1'b1;
        end else if (mem_rvalid_i) begin
            drop_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE) begin
            level_q <= 1'b1;
            base_q  <= csr_i.satp_ppn[19:0];
        end else if ((state_q == S_WAIT) && rvalid && !pte_leaf) begin
            level_q <= 1'b0;
            base_q  <= mem_rdata_i[29:10];  // next table
        end
        if (state_q == S_FETCH) begin
            mem_addr_q <= {base_q, vpn_idx, 2'b00};
        end
        if ((state_q == S_WAIT) && rvalid) begin
            fill_q <= '{asid:      csr_i.asid,
                        vpn:       req_i.vaddr[31:12],
                        superpage: level_q,
                        pte:       mem_rdata_i};
        end
    end

    assign mem_req_o    = mem_req_q;
    assign mem_addr_o   = mem_addr_q;
    assign fill_valid_o = (state_q == S_FILL);
    assign fill_o       = fill_q;
    assign fault_o      = (state_q == S_FAULT);

endmodule

// File: hw/mmu.sv
`include "mmu_defines.svh"

module mmu (
    input  logic              clk,
    input  logic              rst_i,
    input  mmu_pkg::mmu_req_t mmu_req_i,
    input  logic              mmu_req_valid_i,
    input  mmu_pkg::mmu_csr_t mmu_csr_i,
    input  logic              mmu_flush_i,
    output logic [31:0]       mmu_paddr_o,
    output logic              mmu_resp_valid_o,
    output logic              mmu_page_fault_o,
    output logic              mmu_mem_req_o,
    output logic [31:0]       mmu_mem_addr_o,
    input  logic [31:0]       mmu_mem_rdata_i,
    input  logic              mmu_mem_rvalid_i
);
    import mmu_pkg::*;

    tlb_fill_t                    fill;
    tlb_entry_t                   entries [`MMU_TLB_ENTRIES];
    logic [`MMU_TLB_ENTRIES-1:0]  match;
    logic [`MMU_TLB_ENTRIES-1:0]  wr;
    logic                         fill_valid;
    logic                         tlb_hit;
    logic                         tlb_fault;
    logic [31:0]                  tlb_paddr;
    logic                         ptw_fault;
    logic                         miss;

    assign miss = mmu_req_valid_i && mmu_csr_i.enable && !tlb_hit;

    tlb_refill u_refill (
        .clk          (clk),
        .rst_i        (rst_i),
        .fill_valid_i (fill_valid),
        .wr_o         (wr)
    );

    for (genvar i = 0; i < `MMU_TLB_ENTRIES; i++) begin : g_entry
        tlb_entry u_entry (
            .clk     (clk),
            .rst_i   (rst_i),
            .flush_i (mmu_flush_i),
            .wr_i    (wr[i]),
            .fill_i  (fill),
            .vpn_i   (mmu_req_i.vaddr[31:12]),
            .asid_i  (mmu_csr_i.asid),
            .entry_o (entries[i]),
            .match_o (match[i])
        );
    end

    tlb_lookup u_lookup (
        .entries_i (entries),
        .match_i   (match),
        .req_i     (mmu_req_i),
        .csr_i     (mmu_csr_i),
        .hit_o     (tlb_hit),
        .paddr_o   (tlb_paddr),
        .fault_o   (tlb_fault)
    );

    ptw u_ptw (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (mmu_flush_i),
        .miss_i       (miss),
        .req_i        (mmu_req_i),
        .csr_i        (mmu_csr_i),
        .mem_req_o    (mmu_mem_req_o),
        .mem_addr_o   (mmu_mem_addr_o),
        .mem_rdata_i  (mmu_mem_rdata_i),
        .mem_rvalid_i (mmu_mem_rvalid_i),
        .fill_valid_o (fill_valid),
        .fill_o       (fill),
        .fault_o      (ptw_fault)
    );

    // bare mode passes the request straight through
    assign mmu_paddr_o = (mmu_csr_i.enable && tlb_hit) ? tlb_paddr : mmu_req_i.vaddr;
    assign mmu_resp_valid_o = !mmu_csr_i.enable ? mmu_req_valid_i :
                              ((mmu_req_valid_i && tlb_hit) || ptw_fault);
    assign mmu_page_fault_o = mmu_csr_i.enable &&
                              ((mmu_req_valid_i && tlb_fault) || ptw_fault);

endmodule

// File: verification/mmu_props.sv
module mmu_props (
    input logic clk,
    input logic rst_i,
    input logic resp_valid_i,
    input logic page_fault_i,
    input logic mem_req_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // a fault always comes with a response
    a_fault_has_resp: assert property (@(posedge clk) disable iff (rst_i)
        page_fault_i |-> resp_valid_i)
        else $error("page fault raised without a valid response");

    a_mem_req_pulse: assert property (@(posedge clk) disable iff (rst_i)
        mem_req_i |=> !mem_req_i)  // walker reads are single pulses
        else $error("memory request held high for two cycles");

endmodule

bind mmu mmu_props u_props (
    .clk          (clk),
    .rst_i        (rst_i),
    .resp_valid_i (mmu_resp_valid_o),
    .page_fault_i (mmu_page_fault_o),
    .mem_req_i    (mmu_mem_req_o)
);

// File: verification/mmu_tb.sv
`include "mmu_defines.svh"

module mmu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mmu_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam logic [7:0] F_V = 8'(1 << `MMU_PTE_V);
    localparam logic [7:0] F_R = 8'(1 << `MMU_PTE_R);
    localparam logic [7:0] F_W = 8'(1 << `MMU_PTE_W);
    localparam logic [7:0] F_X = 8'(1 << `MMU_PTE_X);
    localparam logic [7:0] F_U = 8'(1 << `MMU_PTE_U);
    localparam logic [7:0] F_A = 8'(1 << `MMU_PTE_A);
    localparam logic [7:0] F_D = 8'(1 << `MMU_PTE_D);
    localparam logic [7:0] F_RWAD = F_V | F_R | F_W | F_A | F_D;
    localparam logic [21:0] ROOT = 22'h00010;

    logic        clk = 1'b0;
    logic        rst_i;
    mmu_req_t    mmu_req_i;
    logic        mmu_req_valid_i;
    mmu_csr_t    mmu_csr_i;
    logic        mmu_flush_i;
    logic [31:0] mmu_paddr_o;
    logic        mmu_resp_valid_o;
    logic        mmu_page_fault_o;
    logic        mmu_mem_req_o;
    logic [31:0] mmu_mem_addr_o;
    logic [31:0] mmu_mem_rdata_i = '0;
    logic        mmu_mem_rvalid_i = 1'b0;

    logic [31:0] pt_mem [logic [31:0]];  // sparse page tables
    logic [31:0] rd_log [$];  // walker read addresses
    int          seed = 18903;
    int          lat;
    logic [31:0] rd_addr;
    int          checks = 0;
    int          errors = 0;

    mmu UUT (.*);

    always #5 clk = ~clk;

    // reads answered 1 to 4 cycles after the request
    always @(negedge clk) begin
        if (mmu_mem_req_o) begin
            rd_addr = mmu_mem_addr_o;
            rd_log.push_back(rd_addr);
            lat = 1 + int'($unsigned($random(seed)) % 4);
            repeat (lat) @(negedge clk);
            mmu_mem_rdata_i = pt_mem.exists(rd_addr) ? pt_mem[rd_addr] : '0;
            mmu_mem_rvalid_i = 1'b1;
            @(negedge clk);
            mmu_mem_rvalid_i = 1'b0;
        end
    end

    function automatic logic [31:0] entry_addr(input logic [21:0] tbl, input logic [9:0] idx);
        return 32'((34'(tbl) << 12) + (34'(idx) << 2));
    endfunction

    function automatic logic [31:0] leaf_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic [31:0] page_paddr(input logic [21:0] ppn, input logic [31:0] va);
        return 32'({ppn, 12'h000} | 34'(va[11:0]));
    endfunction

    task automatic map_page(input logic [31:0] va, input logic [21:0] l0, input logic [31:0] pte);
        pt_mem[entry_addr(ROOT, va[31:22])] = leaf_pte(l0, F_V);  // pointer
        pt_mem[entry_addr(l0, va[21:12])] = pte;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // hold the request until the response, then check it
    task automatic access_check(input logic [31:0] va, input logic st, input logic inst,
                                input logic exp_fault, input logic [31:0] exp_paddr,
                                input int exp_reqs);
        logic        resp_at_once;
        logic [31:0] root_pte;
        @(negedge clk);
        rd_log.delete();
        mmu_req_i = '{vaddr: va, is_store: st, is_inst: inst};
        mmu_req_valid_i = 1'b1;
        #1;
        resp_at_once = mmu_resp_valid_o;  // same cycle as the request
        do begin
            @(negedge clk);
        end while (!mmu_resp_valid_o);
        compare_value("mmu_page_fault_o", 32'(mmu_page_fault_o), 32'(exp_fault));
        if (!exp_fault) compare_value("mmu_paddr_o", mmu_paddr_o, exp_paddr);
        mmu_req_valid_i = 1'b0;
        compare_value("mmu_mem_req_o count", 32'(rd_log.size()), 32'(exp_reqs));
        if (exp_reqs == 0) compare_value("mmu_resp_valid_o", 32'(resp_at_once), 32'd1);
        if (rd_log.size() > 0) begin
            compare_value("mmu_mem_addr_o", rd_log[0], entry_addr(ROOT, va[31:22]));
        end
        if (rd_log.size() > 1) begin
            root_pte = pt_mem[entry_addr(ROOT, va[31:22])];
            compare_value("mmu_mem_addr_o", rd_log[1], entry_addr(root_pte[31:10], va[21:12]));
        end
    endtask

    task automatic pulse_flush();
        @(negedge clk);
        mmu_flush_i = 1'b1;
        @(negedge clk);
        mmu_flush_i = 1'b0;
    endtask

    task automatic test_bare();
        mmu_csr_i.enable = 1'b0;
        access_check(32'h1234_5678, 1'b0, 1'b0, 1'b0, 32'h1234_5678, 0);
        access_check(32'hfedc_ba98, 1'b1, 1'b0, 1'b0, 32'hfedc_ba98, 0);
        mmu_csr_i.enable = 1'b1;
    endtask

    task automatic test_walk_4k();
        map_page(32'h0040_1abc, 22'h11, leaf_pte(22'h22222, F_RWAD));
        access_check(32'h0040_1abc, 1'b0, 1'b0, 1'b0, page_paddr(22'h22222, 32'h0040_1abc), 2);
        access_check(32'h0040_1004, 1'b1, 1'b0, 1'b0, page_paddr(22'h22222, 32'h0040_1004), 0);
    endtask

    task automatic test_superpage();
        pt_mem[entry_addr(ROOT, 10'h030)] = leaf_pte(22'h55400, F_V | F_R | F_X | F_A);
        access_check(32'h0c12_3456, 1'b0, 1'b0, 1'b0, 32'h5552_3456, 1);  // ppn[1] 0x155
        access_check(32'h0c3f_fff0, 1'b0, 1'b1, 1'b0, 32'h557f_fff0, 0);
        pt_mem[entry_addr(ROOT, 10'h040)] = leaf_pte(22'h0a001, F_V | F_R | F_A);
        access_check(32'h1000_0000, 1'b0, 1'b0, 1'b1, '0, 1);  // ppn[0] not zero
    endtask

    task automatic test_permissions();
        map_page(32'h0080_2000, 22'h12, leaf_pte(22'h30000, F_V | F_R | F_A | F_D));
        access_check(32'h0080_2000, 1'b1, 1'b0, 1'b1, '0, 2);
        access_check(32'h0080_2010, 1'b0, 1'b0, 1'b0, page_paddr(22'h30000, 32'h0080_2010), 0);
        map_page(32'h0080_3000, 22'h12, leaf_pte(22'h30001, F_V | F_X | F_A));
        access_check(32'h0080_3000, 1'b0, 1'b0, 1'b1, '0, 2);
        mmu_csr_i.mxr = 1'b1;
        access_check(32'h0080_3000, 1'b0, 1'b0, 1'b0, page_paddr(22'h30001, 32'h0080_3000), 0);
        mmu_csr_i.mxr = 1'b0;
        map_page(32'h0080_4000, 22'h12, leaf_pte(22'h30002, F_RWAD | F_U));
        access_check(32'h0080_4000, 1'b0, 1'b0, 1'b1, '0, 2);
        mmu_csr_i.sum = 1'b1;
        access_check(32'h0080_4000, 1'b1, 1'b0, 1'b0, page_paddr(22'h30002, 32'h0080_4000), 0);
        mmu_csr_i.sum = 1'b0;
        map_page(32'h0080_5000, 22'h12, leaf_pte(22'h30003, F_V | F_R | F_W | F_D));
        access_check(32'h0080_5000, 1'b0, 1'b0, 1'b1, '0, 2);  // A clear
    endtask

    task automatic test_invalid_pte();
        access_check(32'h0140_0000, 1'b0, 1'b0, 1'b1, '0, 1);  // empty root entry
        access_check(32'h0080_6000, 1'b0, 1'b0, 1'b1, '0, 2);  // empty level 0 entry
    endtask

    task automatic test_flush_evict();
        logic [31:0] va;
        access_check(32'h0040_1abc, 1'b0, 1'b0, 1'b0, page_paddr(22'h22222, 32'h0040_1abc), 0);
        pulse_flush();
        access_check(32'h0040_1abc, 1'b0, 1'b0, 1'b0, page_paddr(22'h22222, 32'h0040_1abc), 2);
        pulse_flush();
        for (int i = 0; i <= `MMU_TLB_ENTRIES; i++) begin
            va = 32'h0300_0000 + 32'(i << 12);
            map_page(va, 22'h13, leaf_pte(22'h40000 + 22'(i), F_RWAD));
            access_check(va, 1'b0, 1'b0, 1'b0, page_paddr(22'h40000 + 22'(i), va), 2);
        end
        // remap the two oldest but only page 0 has left the tlb
        for (int i = 0; i < 2; i++) begin
            map_page(32'h0300_0000 + 32'(i << 12), 22'h13, leaf_pte(22'h50000 + 22'(i), F_RWAD));
        end
        access_check(32'h0300_1000, 1'b0, 1'b0, 1'b0, page_paddr(22'h40001, 32'h0300_1000), 0);
        access_check(32'h0300_0000, 1'b0, 1'b0, 1'b0, page_paddr(22'h50000, 32'h0300_0000), 2);
    endtask

    initial begin
        rst_i = 1'b1;
        mmu_req_i = '0;
        mmu_req_valid_i = 1'b0;
        mmu_csr_i = '{enable: 1'b0, satp_ppn: ROOT, asid: 9'h005, mxr: 1'b0, sum: 1'b0};
        mmu_flush_i = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        compare_value("mmu_resp_valid_o", 32'(mmu_resp_valid_o), 32'h0);
        compare_value("mmu_page_fault_o", 32'(mmu_page_fault_o), 32'h0);
        compare_value("mmu_mem_req_o", 32'(mmu_mem_req_o), 32'h0);
        test_bare();
        test_walk_4k();
        test_superpage();
        test_permissions();
        test_invalid_pte();
        test_flush_evict();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // 200 cycles per test
    initial begin
        #(NUM_TESTS * 200 * 10);
        $display("timeout, tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("Errors found");
        $finish;
    end

endmodule

// File: mmu.f
+incdir+common
common/mmu_pkg.sv
tlb/tlb_entry.sv
tlb/tlb_refill.sv
tlb/tlb_lookup.sv
ptw/ptw.sv
hw/mmu.sv
verification/mmu_props.sv
verification/mmu_tb.sv

// File: Makefile
TOP := mmu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mmu.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q "No errors" run.log

clean:
	rm -rf obj_dir run.log
